//--- include/sha2_macros.svh
`ifndef SHA2_MACROS_SVH
`define SHA2_MACROS_SVH

// Bus geometry
`define SHA2_A_WIDTH 8
`define SHA2_D_WIDTH 32

`define SHA2_IN_DEPTH  16  // Two blocks of input beats
`define SHA2_OUT_DEPTH 2

`define SHA2_ROUNDS 64

`endif

//--- hdl/mmio_pkg.sv
`include "sha2_macros.svh"

package mmio_pkg;

    typedef struct packed {
        logic                     rd_en;
        logic [`SHA2_A_WIDTH-1:0] rd_addr;
        logic                     wr_en;
        logic [`SHA2_A_WIDTH-1:0] wr_addr;
        logic [`SHA2_D_WIDTH-1:0] wr_data;
    } mmio_req_t;

    // Register index, from address bits 4:2
    typedef enum logic [2:0] {
        CTRL_0    = 3'd0,
        CTRL_1    = 3'd1,
        DATA_I_LO = 3'd2,
        DATA_I_HI = 3'd3,
        DATA_O_LO = 3'd4,
        DATA_O_HI = 3'd5,
        RSVD_0    = 3'd6,
        RSVD_1    = 3'd7
    } sha2_reg_e;

    typedef struct packed {
        logic        intr_done;  // Sticky
        logic        intr_next;  // Sticky
        logic [28:0] rsvd;
        logic        enable;     // Soft reset when low
    } sha2_ctrl0_t;

    typedef struct packed {
        logic        done;  // Digest queued
        logic        next;  // Input FIFO not full
        logic [25:0] rsvd;
        logic        read;  // Advance output word
        logic [1:0]  mode;
        logic        last;
    } sha2_ctrl1_t;

endpackage

//--- hdl/sha2_pkg.sv
`include "sha2_macros.svh"

package sha2_pkg;

    localparam int SHA2_ROUND_W = $clog2(`SHA2_ROUNDS);

    typedef logic [31:0] sha2_word_t;

    typedef sha2_word_t [0:15] sha2_block_t;  // Word 0 in the top bits

    typedef enum logic [1:0] {
        SHA256 = 2'd0,
        SHA224 = 2'd1
    } sha2_mode_e;

    typedef struct packed {
        logic [63:0] data;  // First message word in the high half
        logic        last;
        sha2_mode_e  mode;
    } sha2_beat_t;

    typedef struct packed {
        sha2_word_t a;
        sha2_word_t b;
        sha2_word_t c;
        sha2_word_t d;
        sha2_word_t e;
        sha2_word_t f;
        sha2_word_t g;
        sha2_word_t h;
    } sha2_state_t;

    typedef struct packed {
        sha2_state_t state;
        sha2_mode_e  mode;
    } sha2_digest_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Constants from FIPS 180-4
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam sha2_word_t SHA2_K [`SHA2_ROUNDS] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
        32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
        32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
        32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
        32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
        32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    function automatic sha2_word_t sha2_k(input logic [SHA2_ROUND_W-1:0] t);
        return SHA2_K[t];
    endfunction

    // Reserved modes fall back to SHA-256
    function automatic sha2_state_t sha2_iv(input sha2_mode_e mode);
        if (mode == SHA224) begin
            return '{32'hc1059ed8, 32'h367cd507, 32'h3070dd17, 32'hf70e5939,
                     32'hffc00b31, 32'h68581511, 32'h64f98fa7, 32'hbefa4fa4};
        end
        return '{32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
                 32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
    endfunction

    function automatic sha2_word_t sha2_ror(input sha2_word_t x, input int unsigned n);
        return (x >> n) | (x << (32 - n));
    endfunction

endpackage

//--- hdl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 4
) (
    input  logic  s_mmio,
    input  logic  rst_i,
    input  logic  flush_i,
    input  logic  push_i,
    input  item_t push_item_i,
    input  logic  pop_i,
    output item_t head_o,
    output logic  full_o,
    output logic  empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;  // Dropped when full
    assign do_pop  = pop_i && !empty_o;
    assign head_o  = mem[rd_ptr_q];

    always_ff @(posedge s_mmio) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge s_mmio) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_item_i;
        end
    end

    a_no_push_full : assert property (@(posedge s_mmio) disable iff (rst_i || flush_i)
        push_i |-> !full_o)
        else $error("sync_fifo: push while full, item dropped");

    a_no_pop_empty : assert property (@(posedge s_mmio) disable iff (rst_i || flush_i)
        pop_i |-> !empty_o)
        else $error("sync_fifo: pop while empty");

endmodule

//--- hdl/sha2_schedule.sv
`timescale 1ns/1ns

module sha2_schedule (
    input  logic                  s_mmio,
    input  logic                  load_i,
    input  sha2_pkg::sha2_block_t block_i,
    input  logic                  step_i,
    output sha2_pkg::sha2_word_t  w_o
);

    import sha2_pkg::*;

    sha2_block_t win_q;  // win_q[0] is W(t)
    sha2_word_t  s0;
    sha2_word_t  s1;
    sha2_word_t  w_new;

    assign w_o = win_q[0];

    // W(t+16) from W(t+14), W(t+9), W(t+1) and W(t)
    assign s0    = sha2_ror(win_q[1], 7) ^ sha2_ror(win_q[1], 18) ^ (win_q[1] >> 3);
    assign s1    = sha2_ror(win_q[14], 17) ^ sha2_ror(win_q[14], 19) ^ (win_q[14] >> 10);
    assign w_new = s1 + win_q[9] + s0 + win_q[0];

    always_ff @(posedge s_mmio) begin
        if (load_i) begin
            win_q <= block_i;
        end else if (step_i) begin
            win_q <= {win_q[1:15], w_new};
        end
    end

endmodule

//--- hdl/sha2_core.sv
`timescale 1ns/1ns
`include "sha2_macros.svh"

module sha2_core (
    input  logic                   s_mmio,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   beat_valid_i,
    input  sha2_pkg::sha2_beat_t   beat_i,
    input  logic                   digest_full_i,
    output logic                   beat_pop_o,
    output logic                   digest_push_o,
    output sha2_pkg::sha2_digest_t digest_o,
    output logic                   busy_o
);

    import sha2_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_GATHER,
        S_ROUNDS,
        S_ADD,
        S_EMIT
    } state_e;

    state_e                  state_q;
    logic [2:0]              beat_cnt_q;
    logic [SHA2_ROUND_W-1:0] rnd_q;
    logic                    first_q;  // Next block starts a message
    logic                    last_q;
    sha2_mode_e              mode_q;
    sha2_block_t             blk_q;
    sha2_block_t             blk_next;
    sha2_state_t             work_q;
    sha2_state_t             chain_q;
    sha2_word_t              w;
    logic                    block_end;

    function automatic sha2_state_t sha2_round(input sha2_state_t s, input sha2_word_t wt,
                                               input sha2_word_t kt);
        sha2_word_t t1;
        sha2_word_t t2;
        t1 = s.h + (sha2_ror(s.e, 6) ^ sha2_ror(s.e, 11) ^ sha2_ror(s.e, 25))
             + ((s.e & s.f) ^ (~s.e & s.g)) + kt + wt;
        t2 = (sha2_ror(s.a, 2) ^ sha2_ror(s.a, 13) ^ sha2_ror(s.a, 22))
             + ((s.a & s.b) ^ (s.a & s.c) ^ (s.b & s.c));
        return '{t1 + t2, s.a, s.b, s.c, s.d + t1, s.e, s.f, s.g};
    endfunction

    function automatic sha2_state_t sha2_add(input sha2_state_t x, input sha2_state_t y);
        return '{x.a + y.a, x.b + y.b, x.c + y.c, x.d + y.d,
                 x.e + y.e, x.f + y.f, x.g + y.g, x.h + y.h};
    endfunction

    assign beat_pop_o    = beat_valid_i && (state_q == S_IDLE || state_q == S_GATHER);
    assign block_end     = beat_pop_o && (beat_cnt_q == 3'd7);
    assign blk_next      = {blk_q[2:15], beat_i.data};
    assign digest_push_o = (state_q == S_EMIT) && !digest_full_i;
    assign digest_o      = '{state: chain_q, mode: mode_q};
    assign busy_o        = (state_q != S_IDLE) || !first_q;

    sha2_schedule u_schedule (
        .s_mmio (s_mmio),
        .load_i (block_end),
        .block_i(blk_next),
        .step_i (state_q == S_ROUNDS),
        .w_o    (w)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge s_mmio) begin
        if (rst_i || flush_i) begin
            state_q    <= S_IDLE;
            beat_cnt_q <= '0;
            rnd_q      <= '0;
            first_q    <= 1'b1;
        end else begin
            case (state_q)
                S_IDLE, S_GATHER: begin
                    if (beat_pop_o) begin
                        beat_cnt_q <= beat_cnt_q + 3'd1;  // Wraps after eight beats
                        state_q    <= block_end ? S_ROUNDS : S_GATHER;
                    end
                end
                S_ROUNDS: begin
                    rnd_q <= rnd_q + 1'b1;
                    if (rnd_q == SHA2_ROUND_W'(`SHA2_ROUNDS - 1)) begin
                        state_q <= S_ADD;
                    end
                end
                S_ADD: begin
                    first_q <= last_q;
                    state_q <= last_q ? S_EMIT : S_IDLE;
                end
                S_EMIT: begin
                    if (!digest_full_i) begin  // Back-pressure from digest FIFO
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge s_mmio) begin
        if (beat_pop_o) begin
            blk_q <= blk_next;
        end
        if (block_end) begin
            last_q <= beat_i.last;
            if (first_q) begin
                mode_q  <= beat_i.mode;
                chain_q <= sha2_iv(beat_i.mode);
                work_q  <= sha2_iv(beat_i.mode);
            end else begin
                work_q <= chain_q;
            end
        end
        if (state_q == S_ROUNDS) begin
            work_q <= sha2_round(work_q, w, sha2_k(rnd_q));
        end
        if (state_q == S_ADD) begin
            chain_q <= sha2_add(chain_q, work_q);
        end
    end

    a_mode_stable : assert property (@(posedge s_mmio) disable iff (rst_i || flush_i)
        (block_end && !first_q) |-> (beat_i.mode == mode_q))
        else $error("sha2_core: mode changed within a message");

endmodule

//--- hdl/mmio_sha2.sv
`timescale 1ns/1ns
`include "sha2_macros.svh"

module mmio_sha2 (
    input  logic                     s_mmio,
    input  logic                     rst_i,
    input  mmio_pkg::mmio_req_t      mmio_req_i,
    output logic [`SHA2_D_WIDTH-1:0] mmio_rdata_o,
    output logic                     irq_o
);

    import mmio_pkg::*;
    import sha2_pkg::*;

    sha2_reg_e                rd_idx;
    sha2_reg_e                wr_idx;
    sha2_ctrl0_t              ctrl0_q;
    sha2_ctrl1_t              ctrl1;
    sha2_ctrl1_t              wr_ctrl1;
    logic [`SHA2_D_WIDTH-1:0] data_lo_q;
    logic [`SHA2_D_WIDTH-1:0] data_hi_q;
    logic [`SHA2_D_WIDTH-1:0] rd_mux;
    logic [1:0]               mode_q;
    logic                     last_q;
    logic                     read_q;
    logic                     beat_push_q;
    logic                     flush;
    logic                     rd_ctrl0;
    logic                     next_d_q;
    logic                     done_d_q;
    logic                     next_rise;
    logic                     done_rise;
    logic [1:0]               word_q;
    logic                     dgst_pop;
    logic [63:0]              out_word;

    sha2_beat_t   beat_in;
    sha2_beat_t   beat_head;
    logic         beat_full;
    logic         beat_empty;
    logic         beat_pop;
    sha2_digest_t dgst_in;
    sha2_digest_t dgst_head;
    logic         dgst_push;
    logic         dgst_full;
    logic         dgst_empty;

    assign rd_idx   = sha2_reg_e'(mmio_req_i.rd_addr[4:2]);
    assign wr_idx   = sha2_reg_e'(mmio_req_i.wr_addr[4:2]);
    assign wr_ctrl1 = sha2_ctrl1_t'(mmio_req_i.wr_data);
    assign rd_ctrl0 = mmio_req_i.rd_en && (rd_idx == CTRL_0);
    assign flush    = !ctrl0_q.enable;
    assign irq_o    = ctrl0_q.intr_done | ctrl0_q.intr_next;

    assign beat_in  = '{data: {data_hi_q, data_lo_q}, last: last_q, mode: sha2_mode_e'(mode_q)};
    assign dgst_pop = read_q && !dgst_empty && (word_q == 2'd3);

    assign next_rise = ctrl1.next & ~next_d_q;
    assign done_rise = ctrl1.done & ~done_d_q;

    always_comb begin
        ctrl1      = '0;
        ctrl1.done = !dgst_empty;
        ctrl1.next = !beat_full;
        ctrl1.mode = mode_q;
        ctrl1.last = last_q;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register writes and interrupts
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge s_mmio) begin
        if (rst_i) begin
            ctrl0_q     <= '0;
            mode_q      <= '0;
            last_q      <= 1'b0;
            read_q      <= 1'b0;
            beat_push_q <= 1'b0;
            next_d_q    <= 1'b1;  // FIFO starts empty, no edge at reset
            done_d_q    <= 1'b0;
        end else begin
            read_q      <= 1'b0;
            beat_push_q <= mmio_req_i.wr_en && (wr_idx == DATA_I_HI);
            next_d_q    <= ctrl1.next;
            done_d_q    <= ctrl1.done;
            if (mmio_req_i.wr_en) begin
                case (wr_idx)
                    CTRL_0: ctrl0_q.enable <= mmio_req_i.wr_data[0];
                    CTRL_1: begin
                        mode_q <= wr_ctrl1.mode;
                        last_q <= wr_ctrl1.last;
                        read_q <= wr_ctrl1.read;
                    end
                    default: ;
                endcase
            end
            ctrl0_q.intr_next <= next_rise | (ctrl0_q.intr_next & ~rd_ctrl0);
            ctrl0_q.intr_done <= done_rise | (ctrl0_q.intr_done & ~rd_ctrl0);
        end
    end

    always_ff @(posedge s_mmio) begin
        if (mmio_req_i.wr_en && wr_idx == DATA_I_LO) begin
            data_lo_q <= mmio_req_i.wr_data;
        end
        if (mmio_req_i.wr_en && wr_idx == DATA_I_HI) begin
            data_hi_q <= mmio_req_i.wr_data;
        end
    end

    // Output word counter, wraps and pops after word 3
    always_ff @(posedge s_mmio) begin
        if (rst_i || flush) begin
            word_q <= '0;
        end else if (read_q && !dgst_empty) begin
            word_q <= word_q + 2'd1;
        end
    end

    always_comb begin
        case (word_q)
            2'd0:    out_word = {dgst_head.state.a, dgst_head.state.b};
            2'd1:    out_word = {dgst_head.state.c, dgst_head.state.d};
            2'd2:    out_word = {dgst_head.state.e, dgst_head.state.f};
            default: out_word = {dgst_head.state.g,
                                 (dgst_head.mode == SHA224) ? 32'h0 : dgst_head.state.h};
        endcase
    end

    always_comb begin
        case (rd_idx)
            CTRL_0:    rd_mux = ctrl0_q;
            CTRL_1:    rd_mux = ctrl1;
            DATA_I_LO: rd_mux = data_lo_q;
            DATA_I_HI: rd_mux = data_hi_q;
            DATA_O_LO: rd_mux = out_word[31:0];
            DATA_O_HI: rd_mux = out_word[63:32];
            default:   rd_mux = '0;
        endcase
    end

    always_ff @(posedge s_mmio) begin
        if (rst_i) begin
            mmio_rdata_o <= '0;
        end else if (mmio_req_i.rd_en) begin
            mmio_rdata_o <= rd_mux;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FIFOs and engine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    sync_fifo #(
        .item_t(sha2_beat_t),
        .DEPTH (`SHA2_IN_DEPTH)
    ) u_beat_fifo (
        .s_mmio     (s_mmio),
        .rst_i      (rst_i),
        .flush_i    (flush),
        .push_i     (beat_push_q),
        .push_item_i(beat_in),
        .pop_i      (beat_pop),
        .head_o     (beat_head),
        .full_o     (beat_full),
        .empty_o    (beat_empty)
    );

    sha2_core u_core (
        .s_mmio       (s_mmio),
        .rst_i        (rst_i),
        .flush_i      (flush),
        .beat_valid_i (!beat_empty),
        .beat_i       (beat_head),
        .digest_full_i(dgst_full),
        .beat_pop_o   (beat_pop),
        .digest_push_o(dgst_push),
        .digest_o     (dgst_in),
        .busy_o       ()
    );

    sync_fifo #(
        .item_t(sha2_digest_t),
        .DEPTH (`SHA2_OUT_DEPTH)
    ) u_dgst_fifo (
        .s_mmio     (s_mmio),
        .rst_i      (rst_i),
        .flush_i    (flush),
        .push_i     (dgst_push),
        .push_item_i(dgst_in),
        .pop_i      (dgst_pop),
        .head_o     (dgst_head),
        .full_o     (dgst_full),
        .empty_o    (dgst_empty)
    );

endmodule

//--- verification/tb_mmio_sha2.sv
`timescale 1ns/1ns
`include "sha2_macros.svh"

module tb_mmio_sha2;

    import mmio_pkg::*;
    import sha2_pkg::*;

    localparam int TIMEOUT = 2000;

    // FIPS 180-4 known answers
    localparam sha2_state_t ABC_256 = {32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
                                       32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad};
    localparam sha2_state_t ABC_224 = {32'h23097d22, 32'h3405d822, 32'h8642a477, 32'hbda255b3,
                                       32'h2aadbce4, 32'hbda0b3f7, 32'he36c9da7, 32'h00000000};
    localparam sha2_state_t TWO_256 = {32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
                                       32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1};

    logic                     s_mmio;
    logic                     rst_i;
    mmio_req_t                mmio_req;
    logic [`SHA2_D_WIDTH-1:0] mmio_rdata;
    logic                     irq;
    sha2_word_t               msg [32];  // Padded message, up to two blocks

    mmio_sha2 DUT (
        .s_mmio      (s_mmio),
        .rst_i       (rst_i),
        .mmio_req_i  (mmio_req),
        .mmio_rdata_o(mmio_rdata),
        .irq_o       (irq)
    );

    initial begin
        s_mmio = 1'b0;
        forever #4 s_mmio = ~s_mmio;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string name, input sha2_word_t exp, input sha2_word_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_state(input string name, input sha2_state_t exp,
                               input sha2_state_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus tasks, all start and end on a falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [`SHA2_A_WIDTH-1:0] reg_addr(input sha2_reg_e idx);
        return {{(`SHA2_A_WIDTH-5){1'b0}}, idx, 2'b00};
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge s_mmio);
    endtask

    task automatic bus_write(input sha2_reg_e idx, input sha2_word_t data);
        mmio_req.wr_en   = 1'b1;
        mmio_req.wr_addr = reg_addr(idx);
        mmio_req.wr_data = data;
        @(negedge s_mmio);
        mmio_req.wr_en   = 1'b0;
    endtask

    task automatic bus_read(input sha2_reg_e idx, output sha2_word_t data);
        mmio_req.rd_en   = 1'b1;
        mmio_req.rd_addr = reg_addr(idx);
        @(negedge s_mmio);
        mmio_req.rd_en   = 1'b0;
        data = mmio_rdata;  // Registered on the rising edge before
    endtask

    task automatic send_beats(input sha2_mode_e mode, input int nbeats, input bit mark_last);
        sha2_ctrl1_t ctrl;
        for (int b = 0; b < nbeats; b++) begin
            ctrl      = '0;
            ctrl.mode = mode;
            ctrl.last = mark_last && (b == nbeats - 1);
            bus_write(DATA_I_LO, msg[2*b+1]);
            bus_write(CTRL_1, ctrl);
            bus_write(DATA_I_HI, msg[2*b]);  // Pushes the beat
            idle($urandom % 4);
        end
    endtask

    task automatic read_digest(output sha2_state_t st);
        sha2_word_t  wd [8];
        sha2_ctrl1_t adv;
        adv      = '0;
        adv.read = 1'b1;
        for (int i = 0; i < 4; i++) begin
            bus_read(DATA_O_HI, wd[2*i]);
            bus_read(DATA_O_LO, wd[2*i+1]);
            bus_write(CTRL_1, adv);
            idle(1);  // Word counter moves a cycle after the strobe
        end
        st = {wd[0], wd[1], wd[2], wd[3], wd[4], wd[5], wd[6], wd[7]};
    endtask

    task automatic check_done(input string name, input logic exp);
        sha2_word_t  v;
        sha2_ctrl1_t c1;
        bus_read(CTRL_1, v);
        c1 = sha2_ctrl1_t'(v);
        check_word(name, 32'(exp), 32'(c1.done));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Waits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_done;
        sha2_word_t  v;
        sha2_ctrl1_t c1;
        int          n;
        n  = 0;
        c1 = '0;
        while (!c1.done && n < TIMEOUT) begin
            bus_read(CTRL_1, v);
            c1 = sha2_ctrl1_t'(v);
            n  = n + 1;
        end
        if (!c1.done) begin
            stop_run("Timeout: no digest became available");
        end
    endtask

    task automatic wait_irq;
        int n;
        n = 0;
        while (!irq && n < TIMEOUT) begin
            idle(1);
            n = n + 1;
        end
        if (!irq) begin
            stop_run("Timeout: the interrupt line never went high");
        end
    endtask

    task automatic wait_two_digests;
        int n;
        n = 0;
        while (!DUT.dgst_full && n < TIMEOUT) begin
            idle(1);
            n = n + 1;
        end
        if (!DUT.dgst_full) begin
            stop_run("Timeout: the digest FIFO never held two digests");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Messages and tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_abc;
        foreach (msg[i]) msg[i] = '0;
        msg[0]  = 32'h61626380;
        msg[15] = 32'h00000018;  // 24-bit length
    endtask

    task automatic load_two_block;
        foreach (msg[i]) msg[i] = '0;
        msg[0]  = 32'h61626364;
        msg[1]  = 32'h62636465;
        msg[2]  = 32'h63646566;
        msg[3]  = 32'h64656667;
        msg[4]  = 32'h65666768;
        msg[5]  = 32'h66676869;
        msg[6]  = 32'h6768696a;
        msg[7]  = 32'h68696a6b;
        msg[8]  = 32'h696a6b6c;
        msg[9]  = 32'h6a6b6c6d;
        msg[10] = 32'h6b6c6d6e;
        msg[11] = 32'h6c6d6e6f;
        msg[12] = 32'h6d6e6f70;
        msg[13] = 32'h6e6f7071;
        msg[14] = 32'h80000000;
        msg[31] = 32'h000001c0;  // 448-bit length
    endtask

    task automatic test_reset;
        sha2_word_t  v;
        sha2_ctrl1_t exp;
        exp      = '0;
        exp.next = 1'b1;
        bus_read(CTRL_0, v);
        check_word("reset ctrl0", 32'h0, v);
        bus_read(CTRL_1, v);
        check_word("reset ctrl1", exp, v);
        bus_read(RSVD_0, v);
        check_word("reset rsvd0", 32'h0, v);
        bus_read(RSVD_1, v);
        check_word("reset rsvd1", 32'h0, v);
        check_word("reset irq", 32'h0, 32'(irq));
        bus_write(CTRL_0, 32'h1);  // Enable
    endtask

    task automatic test_hash(input string name, input sha2_mode_e mode, input int nblk,
                             input sha2_state_t exp);
        sha2_state_t st;
        send_beats(mode, nblk * 8, 1'b1);
        wait_done();
        read_digest(st);
        check_state(name, exp, st);
        check_done({name, " done"}, 1'b0);
    endtask

    task automatic test_chaining;
        sha2_state_t st;
        load_abc();
        send_beats(SHA256, 8, 1'b1);
        send_beats(SHA256, 8, 1'b1);
        wait_two_digests();
        read_digest(st);
        check_state("chain first", ABC_256, st);
        read_digest(st);
        check_state("chain second", ABC_256, st);
        check_done("chain done", 1'b0);
    endtask

    task automatic test_irq;
        sha2_word_t  v;
        sha2_state_t st;
        bus_read(CTRL_0, v);  // Clears flags left by earlier tests
        check_word("irq cleared", 32'h0, 32'(irq));
        load_abc();
        send_beats(SHA256, 8, 1'b1);
        wait_irq();
        bus_read(CTRL_0, v);
        check_word("irq ctrl0", 32'h80000001, v);
        check_word("irq falls", 32'h0, 32'(irq));
        read_digest(st);
        check_state("irq digest", ABC_256, st);
    endtask

    task automatic test_soft_reset;
        sha2_ctrl1_t adv;
        adv      = '0;
        adv.read = 1'b1;
        load_abc();
        send_beats(SHA256, 8, 1'b1);  // Leaves a digest queued
        wait_done();
        bus_write(CTRL_1, adv);  // Output word off word 0
        send_beats(SHA256, 3, 1'b0);  // Partial block
        idle(4);
        bus_write(CTRL_0, 32'h0);
        idle(2);
        bus_write(CTRL_0, 32'h1);
        check_done("soft reset done", 1'b0);
        test_hash("soft reset abc", SHA256, 1, ABC_256);
    endtask

    initial begin
        mmio_req = '0;
        rst_i    = 1'b1;
        void'($urandom(32'ha6fa));
        repeat (3) @(posedge s_mmio);
        @(negedge s_mmio);
        rst_i = 1'b0;

        test_reset();
        load_abc();
        test_hash("sha256 abc", SHA256, 1, ABC_256);
        load_abc();
        test_hash("sha224 abc", SHA224, 1, ABC_224);
        load_two_block();
        test_hash("sha256 two block", SHA256, 2, TWO_256);
        test_chaining();
        test_irq();
        test_soft_reset();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
hdl/mmio_pkg.sv
hdl/sha2_pkg.sv
hdl/sync_fifo.sv
hdl/sha2_schedule.sv
hdl/sha2_core.sv
hdl/mmio_sha2.sv
verification/tb_mmio_sha2.sv
